//--- flist.f
verilog/periph_pkg.sv
verilog/reg_bus_if.sv
verilog/obi_to_reg.sv
verilog/reg_demux.sv
verilog/soc_ctrl.sv
verilog/gpio.sv
verilog/intr_ctrl.sv
verilog/peripheral_subsystem.sv
dv/tb_peripheral_subsystem.sv

//--- Makefile
# Verilator lint and simulation of the peripheral subsystem

VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_peripheral_subsystem
RTL_TOP    ?= peripheral_subsystem
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

# Pass or fail comes from the log, not from the exit status of the run
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_peripheral_subsystem.sv
// ##########################################################################
// Self-checking testbench, OBI driver and a stalling external port model
// Stops at the first mismatch, all inputs change on the falling clock edge
// ##########################################################################

module tb_peripheral_subsystem
  import periph_pkg::*;
();

  localparam int MAX_WAIT = 64;

  logic                      clk_i;
  logic                      arst_n_i;
  logic                      boot_select_i;
  logic                      execute_from_flash_i;
  logic                      obi_req_i;
  logic                      obi_we_i;
  logic [ADDR_W-1:0]         obi_addr_i;
  logic [DATA_W-1:0]         obi_wdata_i;
  logic                      obi_gnt_o;
  logic                      obi_rvalid_o;
  logic [DATA_W-1:0]         obi_rdata_o;
  logic                      exit_valid_o;
  logic [DATA_W-1:0]         exit_value_o;
  logic [NUM_GPIO-1:0]       gpio_i;
  logic [NUM_GPIO-1:0]       gpio_o;
  logic [NUM_GPIO-1:0]       gpio_en_o;
  logic [EXT_NINTERRUPT-1:0] intr_ext_i;
  logic                      irq_o;
  logic                      msip_o;
  logic                      ext_valid_o;
  logic                      ext_write_o;
  logic [ADDR_W-1:0]         ext_addr_o;
  logic [DATA_W-1:0]         ext_wdata_o;
  logic                      ext_ready_i;
  logic [DATA_W-1:0]         ext_rdata_i;

  // External peripheral model
  logic [DATA_W-1:0] ext_mem [16];
  logic [ADDR_W-1:0] ext_last_addr;
  int                ext_stall;
  int                ext_count;
  logic              in_flight;

  peripheral_subsystem peripheral_subsystem_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic stop_run();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on a failed check");
  endtask

  task automatic check_eq(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                          input string what);
    assert (got === exp) else begin
      $display("ERROR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic wait_irq(input logic exp);
    int cnt;
    cnt = 0;
    while (irq_o !== exp) begin
      if (cnt == MAX_WAIT) begin
        $display("Timeout at %0t: irq_o never became %0b", $time, exp);
        stop_run();
      end
      cnt++;
      @(negedge clk_i);
    end
  endtask

  // Called on a falling edge, returns on the falling edge of the rvalid cycle
  task automatic bus_access(input logic we, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata);
    int cnt;
    obi_req_i   = 1'b1;
    obi_we_i    = we;
    obi_addr_i  = addr;
    obi_wdata_i = wdata;
    cnt = 0;
    while (!obi_gnt_o) begin
      if (cnt == MAX_WAIT) begin
        $display("Timeout at %0t: no grant for address 0x%08h", $time, addr);
        stop_run();
      end
      cnt++;
      @(negedge clk_i);
    end
    @(negedge clk_i);
    obi_req_i = 1'b0;
    cnt = 1;
    while (!obi_rvalid_o) begin
      if (cnt == MAX_WAIT) begin
        $display("Timeout at %0t: no rvalid for address 0x%08h", $time, addr);
        stop_run();
      end
      cnt++;
      @(negedge clk_i);
    end
    rdata = obi_rdata_o;
    // Internal targets and unmapped space never stall
    if (addr[15:12] != EXT_BASE[15:12]) begin
      assert (cnt == 2) else begin
        $display("ERROR %0t: rvalid %0d cycles after the grant, expected 2", $time, cnt);
        stop_run();
      end
    end
  endtask

  task automatic obi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0] ignored;
    bus_access(1'b1, addr, wdata, ignored);
  endtask

  task automatic obi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata);
    bus_access(1'b0, addr, '0, rdata);
  endtask

  // Upper 16 bits are not decoded, so they get random values
  function automatic logic [ADDR_W-1:0] make_addr(input logic [15:0] base,
                                                  input logic [11:0] offset);
    return {16'($urandom), base[15:12], offset};
  endfunction

  function automatic logic [ADDR_W-1:0] reg_addr(input logic [15:0] base,
                                                 input logic [4:0] offset);
    return make_addr(base, {7'b0, offset});
  endfunction

  function automatic logic [NUM_SRC-1:0] src_vector(input logic [NUM_GPIO-1:0] gpio_status,
                                                    input logic [EXT_NINTERRUPT-1:0] ext);
    return {3'b0, ext, gpio_status, 1'b0};
  endfunction

  function automatic logic [DATA_W-1:0] lowest_id(input logic [NUM_SRC-1:0] active);
    logic [DATA_W-1:0] id;
    id = '0;
    for (int i = 1; i < NUM_SRC; i++) begin
      if (active[i] && id == '0) id = DATA_W'(i);
    end
    return id;
  endfunction

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_flight <= 1'b0;
    end else if (obi_req_i && obi_gnt_o) begin
      in_flight <= 1'b1;
    end else if (obi_rvalid_o) begin
      in_flight <= 1'b0;
    end
  end

  gnt_low_in_flight: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                      in_flight |-> !obi_gnt_o)
    else begin
      $display("ERROR %0t: grant given while an access is in flight", $time);
      stop_run();
    end

  ext_only_in_flight: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                       ext_valid_o |-> in_flight)
    else begin
      $display("ERROR %0t: external access without an OBI access in flight", $time);
      stop_run();
    end

  // External peripheral, ready after 0 to 3 stall cycles
  initial begin
    ext_ready_i   = 1'b0;
    ext_rdata_i   = '0;
    ext_stall     = -1;
    ext_count     = 0;
    ext_last_addr = '0;
    for (int i = 0; i < 16; i++) ext_mem[i] = DATA_W'(32'h0101_1011 * (i + 1));
    forever begin
      @(negedge clk_i);
      if (!arst_n_i) begin
        ext_ready_i = 1'b0;
        ext_stall   = -1;
      end else if (ext_ready_i) begin
        // Transfer happened on the last rising edge
        ext_ready_i = 1'b0;
        ext_rdata_i = '0;
        ext_stall   = -1;
      end else if (ext_valid_o) begin
        if (ext_stall < 0) ext_stall = int'($urandom_range(0, 3));
        if (ext_stall == 0) begin
          ext_ready_i   = 1'b1;
          ext_last_addr = ext_addr_o;
          ext_count++;
          if (ext_write_o) ext_mem[ext_addr_o[5:2]] = ext_wdata_o;
          else ext_rdata_i = ext_mem[ext_addr_o[5:2]];
        end else begin
          ext_stall--;
        end
      end
    end
  end

  initial begin
    logic [DATA_W-1:0]         data;
    logic [DATA_W-1:0]         rdata;
    logic [DATA_W-1:0]         id;
    logic [ADDR_W-1:0]         addr;
    logic [11:0]               offset;
    logic [3:0]                region;
    logic [NUM_GPIO-1:0]       pins;
    logic [NUM_GPIO-1:0]       gpio_ie;
    logic [NUM_GPIO-1:0]       status;
    logic [NUM_SRC-1:0]        enable;
    logic [NUM_SRC-1:0]        active;
    logic [EXT_NINTERRUPT-1:0] ext;
    logic [DATA_W-1:0]         exp_exit_value;
    logic                      exp_exit_valid;
    logic [NUM_GPIO-1:0]       exp_gpio_out;
    logic [NUM_GPIO-1:0]       exp_gpio_en;
    logic                      exp_msip;
    int                        pin;
    int                        count;

    void'($urandom(259));
    arst_n_i             = 1'b0;
    boot_select_i        = 1'b0;
    execute_from_flash_i = 1'b0;
    obi_req_i            = 1'b0;
    obi_we_i             = 1'b0;
    obi_addr_i           = '0;
    obi_wdata_i          = '0;
    gpio_i               = '0;
    intr_ext_i           = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    check_eq(DATA_W'(obi_gnt_o), 1, "obi_gnt_o after reset");
    check_eq(DATA_W'({obi_rvalid_o, ext_valid_o, exit_valid_o, irq_o, msip_o}), 0,
             "control outputs after reset");
    check_eq(DATA_W'({gpio_o, gpio_en_o}), 0, "GPIO outputs after reset");

    // SoC control
    exp_exit_value = $urandom;
    obi_write(reg_addr(SOC_CTRL_BASE, EXIT_VALUE), exp_exit_value);
    check_eq(exit_value_o, exp_exit_value, "exit_value_o");
    obi_read(reg_addr(SOC_CTRL_BASE, EXIT_VALUE), rdata);
    check_eq(rdata, exp_exit_value, "EXIT_VALUE read-back");
    // Both values of bit 0
    data = $urandom;
    for (int r = 0; r < 2; r++) begin
      exp_exit_valid = data[0];
      obi_write(reg_addr(SOC_CTRL_BASE, EXIT_VALID), data);
      check_eq(DATA_W'(exit_valid_o), DATA_W'(exp_exit_valid), "exit_valid_o");
      obi_read(reg_addr(SOC_CTRL_BASE, EXIT_VALID), rdata);
      check_eq(rdata, DATA_W'(exp_exit_valid), "EXIT_VALID read-back");
      data = ~data;
    end
    for (int s = 0; s < 4; s++) begin
      boot_select_i        = s[0];
      execute_from_flash_i = s[1];
      obi_read(reg_addr(SOC_CTRL_BASE, BOOT_MODE), rdata);
      check_eq(rdata, DATA_W'(s), "BOOT_MODE");
    end

    // GPIO outputs and inputs
    data = $urandom;
    exp_gpio_out = data[NUM_GPIO-1:0];
    obi_write(reg_addr(GPIO_BASE, GPIO_OUT), data);
    check_eq(DATA_W'(gpio_o), DATA_W'(exp_gpio_out), "gpio_o");
    obi_read(reg_addr(GPIO_BASE, GPIO_OUT), rdata);
    check_eq(rdata, DATA_W'(exp_gpio_out), "GPIO_OUT read-back");
    data = $urandom;
    exp_gpio_en = data[NUM_GPIO-1:0];
    obi_write(reg_addr(GPIO_BASE, GPIO_EN), data);
    check_eq(DATA_W'(gpio_en_o), DATA_W'(exp_gpio_en), "gpio_en_o");
    obi_read(reg_addr(GPIO_BASE, GPIO_EN), rdata);
    check_eq(rdata, DATA_W'(exp_gpio_en), "GPIO_EN read-back");
    pins   = NUM_GPIO'($urandom);
    gpio_i = pins;
    wait_cycles(4);
    obi_read(reg_addr(GPIO_BASE, GPIO_IN), rdata);
    check_eq(rdata, DATA_W'(pins), "GPIO_IN");
    gpio_i = '0;
    wait_cycles(4);

    // GPIO edge interrupts and claim
    for (int r = 0; r < 4; r++) begin
      gpio_ie = NUM_GPIO'($urandom);
      enable  = NUM_SRC'($urandom);
      pins    = NUM_GPIO'($urandom);
      // At least one pin reaches irq_o
      pin = int'($urandom_range(0, NUM_GPIO - 1));
      gpio_ie[pin]    = 1'b1;
      pins[pin]       = 1'b1;
      enable[pin + 1] = 1'b1;
      obi_write(reg_addr(GPIO_BASE, GPIO_INTR_EN), DATA_W'(gpio_ie));
      obi_write(reg_addr(INTR_BASE, INTR_ENABLE), DATA_W'(enable));
      gpio_i = pins;
      wait_irq(1'b1);
      status = pins & gpio_ie;
      obi_read(reg_addr(GPIO_BASE, GPIO_INTR_STATUS), rdata);
      check_eq(rdata, DATA_W'(status), "GPIO_INTR_STATUS");
      active = src_vector(status, '0) & enable;
      while (active != '0) begin
        id = lowest_id(active);
        obi_read(reg_addr(INTR_BASE, INTR_CLAIM), rdata);
        check_eq(rdata, id, "INTR_CLAIM");
        pin = int'(id) - 1;
        obi_write(reg_addr(GPIO_BASE, GPIO_INTR_STATUS), DATA_W'(1) << pin);
        status[pin] = 1'b0;
        active = src_vector(status, '0) & enable;
        wait_irq(|active);
      end
      obi_write(reg_addr(GPIO_BASE, GPIO_INTR_STATUS), '1);
      obi_read(reg_addr(INTR_BASE, INTR_CLAIM), rdata);
      check_eq(rdata, 0, "INTR_CLAIM with nothing pending");
      gpio_i = '0;
      wait_cycles(4);
    end

    // External interrupt lines
    for (int r = 0; r < 4; r++) begin
      enable = NUM_SRC'($urandom);
      ext    = EXT_NINTERRUPT'($urandom);
      obi_write(reg_addr(INTR_BASE, INTR_ENABLE), DATA_W'(enable));
      intr_ext_i = ext;
      wait_cycles(2);
      active = src_vector('0, ext) & enable;
      wait_irq(|active);
      obi_read(reg_addr(INTR_BASE, INTR_PENDING), rdata);
      check_eq(rdata, DATA_W'(src_vector('0, ext)), "INTR_PENDING");
      obi_read(reg_addr(INTR_BASE, INTR_CLAIM), rdata);
      check_eq(rdata, lowest_id(active), "INTR_CLAIM for external lines");
      intr_ext_i = '0;
      wait_irq(1'b0);
    end

    // Software interrupt, both values of bit 0
    data = $urandom;
    for (int r = 0; r < 2; r++) begin
      exp_msip = data[0];
      obi_write(reg_addr(INTR_BASE, INTR_MSIP), data);
      check_eq(DATA_W'(msip_o), DATA_W'(exp_msip), "msip_o");
      obi_read(reg_addr(INTR_BASE, INTR_MSIP), rdata);
      check_eq(rdata, DATA_W'(exp_msip), "INTR_MSIP read-back");
      data = ~data;
    end

    // External port under random stalls
    for (int n = 0; n < 16; n++) begin
      offset = {10'($urandom), 2'b00};
      addr   = make_addr(EXT_BASE, offset);
      count  = ext_count;
      if ($urandom_range(0, 1) == 1) begin
        data = $urandom;
        obi_write(addr, data);
        check_eq(ext_mem[offset[5:2]], data, "external memory word");
      end else begin
        obi_read(addr, rdata);
        check_eq(rdata, ext_mem[offset[5:2]], "external read data");
      end
      check_eq(ext_last_addr, {20'b0, offset}, "external local offset");
      check_eq(DATA_W'(ext_count - count), 1, "external transfers per access");
    end

    // Unmapped regions 0x4 to 0xF
    count = ext_count;
    for (int n = 0; n < 8; n++) begin
      region = 4'($urandom_range(4, 15));
      addr   = {16'($urandom), region, 7'b0, 3'($urandom_range(0, 4)), 2'b00};
      obi_write(addr, $urandom);
      obi_read(addr, rdata);
      check_eq(rdata, 0, "unmapped read");
    end
    check_eq(exit_value_o, exp_exit_value, "exit_value_o after unmapped writes");
    check_eq(DATA_W'(exit_valid_o), DATA_W'(exp_exit_valid), "exit_valid_o after unmapped");
    check_eq(DATA_W'(gpio_o), DATA_W'(exp_gpio_out), "gpio_o after unmapped writes");
    check_eq(DATA_W'(gpio_en_o), DATA_W'(exp_gpio_en), "gpio_en_o after unmapped writes");
    check_eq(DATA_W'(msip_o), DATA_W'(exp_msip), "msip_o after unmapped writes");
    check_eq(DATA_W'(ext_count - count), 0, "external transfers for unmapped accesses");
    obi_read(reg_addr(GPIO_BASE, GPIO_INTR_EN), rdata);
    check_eq(rdata, DATA_W'(gpio_ie), "GPIO_INTR_EN after unmapped writes");
    obi_read(reg_addr(INTR_BASE, INTR_ENABLE), rdata);
    check_eq(rdata, DATA_W'(enable), "INTR_ENABLE after unmapped writes");

    $display("Done: no errors");
    $finish;
  end

endmodule : tb_peripheral_subsystem

//--- verilog/peripheral_subsystem.sv
// ##########################################################################
// Peripheral subsystem, OBI slave in, four register targets behind it
// The external peripheral port completes on ext_ready_i, it may stall
// ##########################################################################

module peripheral_subsystem
  import periph_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  input  logic                      boot_select_i,
  input  logic                      execute_from_flash_i,

  // OBI slave
  input  logic                      obi_req_i,
  input  logic                      obi_we_i,
  input  logic [ADDR_W-1:0]         obi_addr_i,
  input  logic [DATA_W-1:0]         obi_wdata_i,
  output logic                      obi_gnt_o,
  output logic                      obi_rvalid_o,
  output logic [DATA_W-1:0]         obi_rdata_o,

  output logic                      exit_valid_o,
  output logic [DATA_W-1:0]         exit_value_o,

  input  logic [NUM_GPIO-1:0]       gpio_i,
  output logic [NUM_GPIO-1:0]       gpio_o,
  output logic [NUM_GPIO-1:0]       gpio_en_o,

  input  logic [EXT_NINTERRUPT-1:0] intr_ext_i,
  output logic                      irq_o,
  output logic                      msip_o,

  // External peripheral port
  output logic                      ext_valid_o,
  output logic                      ext_write_o,
  output logic [ADDR_W-1:0]         ext_addr_o,
  output logic [DATA_W-1:0]         ext_wdata_o,
  input  logic                      ext_ready_i,
  input  logic [DATA_W-1:0]         ext_rdata_i
);

  reg_bus_if periph_bus ();
  reg_bus_if soc_bus ();
  reg_bus_if gpio_bus ();
  reg_bus_if intr_bus ();
  reg_bus_if ext_bus ();

  logic [NUM_GPIO-1:0] gpio_intr;
  logic [NUM_SRC-1:0]  intr_src;

  // ID 0 tied low, GPIO on 1 to 8, external lines above
  assign intr_src = {{(NUM_SRC - 1 - NUM_GPIO - EXT_NINTERRUPT){1'b0}}, intr_ext_i,
                     gpio_intr, 1'b0};

  obi_to_reg obi_to_reg_inst (
    .clk_i,
    .arst_n_i,
    .obi_req_i,
    .obi_we_i,
    .obi_addr_i,
    .obi_wdata_i,
    .obi_gnt_o,
    .obi_rvalid_o,
    .obi_rdata_o,
    .bus(periph_bus.host)
  );

  reg_demux reg_demux_inst (
    .periph_bus(periph_bus.device),
    .soc_bus   (soc_bus.host),
    .gpio_bus  (gpio_bus.host),
    .intr_bus  (intr_bus.host),
    .ext_bus   (ext_bus.host)
  );

  soc_ctrl soc_ctrl_inst (
    .clk_i,
    .arst_n_i,
    .bus(soc_bus.device),
    .boot_select_i,
    .execute_from_flash_i,
    .exit_valid_o,
    .exit_value_o
  );

  gpio gpio_inst (
    .clk_i,
    .arst_n_i,
    .bus   (gpio_bus.device),
    .gpio_i,
    .gpio_o,
    .gpio_en_o,
    .intr_o(gpio_intr)
  );

  intr_ctrl intr_ctrl_inst (
    .clk_i,
    .arst_n_i,
    .bus       (intr_bus.device),
    .intr_src_i(intr_src),
    .irq_o,
    .msip_o
  );

  assign ext_valid_o   = ext_bus.valid;
  assign ext_write_o   = ext_bus.write;
  assign ext_addr_o    = ext_bus.addr;
  assign ext_wdata_o   = ext_bus.wdata;
  assign ext_bus.ready = ext_ready_i;
  assign ext_bus.rdata = ext_rdata_i;

endmodule : peripheral_subsystem

//--- verilog/intr_ctrl.sv
// ##########################################################################
// Cut-down PLIC, level sources, no priorities and no threshold
// Claim is a plain read, sources clear at their origin
// ##########################################################################

module intr_ctrl
  import periph_pkg::*;
(
  input  logic               clk_i,
  input  logic               arst_n_i,
  reg_bus_if.device          bus,
  input  logic [NUM_SRC-1:0] intr_src_i,
  output logic               irq_o,
  output logic               msip_o
);

  logic [NUM_SRC-1:0]  pending_q;
  logic [NUM_SRC-1:0]  enable_q;
  logic [NUM_SRC-1:0]  active;
  logic [SRC_ID_W-1:0] claim_id;
  logic                msip_q;
  logic                irq_q;
  logic                write_en;

  assign bus.ready = 1'b1;
  assign write_en  = bus.valid && bus.write;
  assign active    = pending_q & enable_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
      msip_q    <= 1'b0;
      irq_q     <= 1'b0;
    end else begin
      // ID 0 means no interrupt
      pending_q <= intr_src_i & ~NUM_SRC'(1);
      irq_q     <= |active;
      if (write_en) begin
        case (bus.addr[4:2])
          INTR_ENABLE[4:2]: enable_q <= bus.wdata[NUM_SRC-1:0];
          INTR_MSIP[4:2]:   msip_q <= bus.wdata[0];
          default: ;
        endcase
      end
    end
  end

  // Lowest active ID wins
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (active[i]) claim_id = SRC_ID_W'(i);
    end
  end

  always_comb begin
    case (bus.addr[4:2])
      INTR_PENDING[4:2]: bus.rdata = DATA_W'(pending_q);
      INTR_ENABLE[4:2]:  bus.rdata = DATA_W'(enable_q);
      INTR_CLAIM[4:2]:   bus.rdata = DATA_W'(claim_id);
      INTR_MSIP[4:2]:    bus.rdata = DATA_W'(msip_q);
      default:           bus.rdata = '0;
    endcase
  end

  assign irq_o  = irq_q;
  assign msip_o = msip_q;

endmodule : intr_ctrl

//--- verilog/gpio.sv
// ##########################################################################
// GPIO block, inputs pass a two-flop synchronizer before edge detection
// Status bits are write-1-to-clear, a new edge wins over a clear
// ##########################################################################

module gpio
  import periph_pkg::*;
(
  input  logic                clk_i,
  input  logic                arst_n_i,
  reg_bus_if.device           bus,
  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_en_o,
  output logic [NUM_GPIO-1:0] intr_o
);

  logic [NUM_GPIO-1:0] meta_q, sync_q, prev_q;
  logic [NUM_GPIO-1:0] out_q, en_q, intr_en_q, status_q;
  logic [NUM_GPIO-1:0] rise, clear;
  logic                write_en;

  assign bus.ready = 1'b1;
  assign write_en  = bus.valid && bus.write;
  assign rise      = sync_q & ~prev_q;
  assign clear     = (write_en && bus.addr[4:2] == GPIO_INTR_STATUS[4:2]) ?
                     bus.wdata[NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      meta_q    <= '0;
      sync_q    <= '0;
      prev_q    <= '0;
      out_q     <= '0;
      en_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
    end else begin
      meta_q   <= gpio_i;
      sync_q   <= meta_q;
      prev_q   <= sync_q;
      status_q <= (status_q & ~clear) | (rise & intr_en_q);
      if (write_en) begin
        case (bus.addr[4:2])
          GPIO_OUT[4:2]:     out_q <= bus.wdata[NUM_GPIO-1:0];
          GPIO_EN[4:2]:      en_q <= bus.wdata[NUM_GPIO-1:0];
          GPIO_INTR_EN[4:2]: intr_en_q <= bus.wdata[NUM_GPIO-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (bus.addr[4:2])
      GPIO_IN[4:2]:          bus.rdata = DATA_W'(sync_q);
      GPIO_OUT[4:2]:         bus.rdata = DATA_W'(out_q);
      GPIO_EN[4:2]:          bus.rdata = DATA_W'(en_q);
      GPIO_INTR_EN[4:2]:     bus.rdata = DATA_W'(intr_en_q);
      GPIO_INTR_STATUS[4:2]: bus.rdata = DATA_W'(status_q);
      default:               bus.rdata = '0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = en_q;
  assign intr_o    = status_q;

endmodule : gpio

//--- verilog/soc_ctrl.sv
// ##########################################################################
// SoC control, exit status and boot strap read-back
// ##########################################################################

module soc_ctrl
  import periph_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  reg_bus_if.device         bus,
  input  logic              boot_select_i,
  input  logic              execute_from_flash_i,
  output logic              exit_valid_o,
  output logic [DATA_W-1:0] exit_value_o
);

  logic              exit_valid_q;
  logic [DATA_W-1:0] exit_value_q;
  logic              write_en;

  assign bus.ready = 1'b1;
  assign write_en  = bus.valid && bus.write;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (write_en) begin
      case (bus.addr[4:2])
        EXIT_VALID[4:2]: exit_valid_q <= bus.wdata[0];
        EXIT_VALUE[4:2]: exit_value_q <= bus.wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (bus.addr[4:2])
      EXIT_VALID[4:2]: bus.rdata = DATA_W'(exit_valid_q);
      EXIT_VALUE[4:2]: bus.rdata = exit_value_q;
      BOOT_MODE[4:2]:  bus.rdata = DATA_W'({execute_from_flash_i, boot_select_i});
      default:         bus.rdata = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

//--- verilog/reg_demux.sv
// ##########################################################################
// Combinational address decoder and demux to the four register targets
// Unmapped accesses complete at once, reads return zero
// ##########################################################################

module reg_demux
  import periph_pkg::*;
(
  reg_bus_if.device periph_bus,
  reg_bus_if.host   soc_bus,
  reg_bus_if.host   gpio_bus,
  reg_bus_if.host   intr_bus,
  reg_bus_if.host   ext_bus
);

  periph_sel_e       sel;
  logic [ADDR_W-1:0] local_addr;

  always_comb begin
    case (periph_bus.addr[15:12])
      SOC_CTRL_BASE[15:12]: sel = SEL_SOC_CTRL;
      GPIO_BASE[15:12]:     sel = SEL_GPIO;
      INTR_BASE[15:12]:     sel = SEL_INTR;
      EXT_BASE[15:12]:      sel = SEL_EXT;
      default:              sel = SEL_NONE;
    endcase
  end

  assign local_addr = periph_bus.addr & OFFSET_MASK;

  // Request side, valid only towards the selected target
  assign soc_bus.valid  = periph_bus.valid && (sel == SEL_SOC_CTRL);
  assign gpio_bus.valid = periph_bus.valid && (sel == SEL_GPIO);
  assign intr_bus.valid = periph_bus.valid && (sel == SEL_INTR);
  assign ext_bus.valid  = periph_bus.valid && (sel == SEL_EXT);

  assign {soc_bus.write, gpio_bus.write, intr_bus.write, ext_bus.write} = {4{periph_bus.write}};
  assign {soc_bus.addr, gpio_bus.addr, intr_bus.addr, ext_bus.addr}     = {4{local_addr}};
  assign {soc_bus.wdata, gpio_bus.wdata, intr_bus.wdata, ext_bus.wdata} = {4{periph_bus.wdata}};

  // Response side
  always_comb begin
    periph_bus.ready = 1'b1;
    periph_bus.rdata = '0;
    case (sel)
      SEL_SOC_CTRL: begin
        periph_bus.ready = soc_bus.ready;
        periph_bus.rdata = soc_bus.rdata;
      end
      SEL_GPIO: begin
        periph_bus.ready = gpio_bus.ready;
        periph_bus.rdata = gpio_bus.rdata;
      end
      SEL_INTR: begin
        periph_bus.ready = intr_bus.ready;
        periph_bus.rdata = intr_bus.rdata;
      end
      SEL_EXT: begin
        periph_bus.ready = ext_bus.ready;
        periph_bus.rdata = ext_bus.rdata;
      end
      default: ;
    endcase
  end

endmodule : reg_demux

//--- verilog/obi_to_reg.sv
// ##########################################################################
// OBI slave to register bus bridge, one access in flight at a time
// No IDs and no byte enables, every write is a full word
// ##########################################################################

module obi_to_reg
  import periph_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              obi_req_i,
  input  logic              obi_we_i,
  input  logic [ADDR_W-1:0] obi_addr_i,
  input  logic [DATA_W-1:0] obi_wdata_i,
  output logic              obi_gnt_o,
  output logic              obi_rvalid_o,
  output logic [DATA_W-1:0] obi_rdata_o,
  reg_bus_if.host           bus
);

  bridge_state_e     state_q, state_d;
  logic              we_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [DATA_W-1:0] rdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (obi_req_i) state_d = ISSUE;
      ISSUE:   if (bus.ready) state_d = RESPOND;
      RESPOND: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (obi_gnt_o && obi_req_i) begin
      we_q    <= obi_we_i;
      addr_q  <= obi_addr_i;
      wdata_q <= obi_wdata_i;
    end
    // Transfer cycle
    if (state_q == ISSUE && bus.ready) rdata_q <= bus.rdata;
  end

  assign obi_gnt_o    = (state_q == IDLE);
  assign obi_rvalid_o = (state_q == RESPOND);
  assign obi_rdata_o  = rdata_q;

  assign bus.valid = (state_q == ISSUE);
  assign bus.write = we_q;
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;

endmodule : obi_to_reg

//--- verilog/reg_bus_if.sv
// ##########################################################################
// Register bus, host holds the request stable until ready with valid
// ##########################################################################

interface reg_bus_if
  import periph_pkg::*;
();

  logic              valid;
  logic              write;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic              ready;
  logic [DATA_W-1:0] rdata;

  modport host(output valid, write, addr, wdata, input ready, rdata);

  modport device(input valid, write, addr, wdata, output ready, rdata);

endinterface : reg_bus_if

//--- verilog/periph_pkg.sv
// ##########################################################################
// Sizes, address map and register offsets of the peripheral subsystem
// Regions decode on address bits 15:12, registers on bits 4:2
// ##########################################################################

package periph_pkg;

  localparam int ADDR_W         = 32;
  localparam int DATA_W         = 32;
  localparam int NUM_GPIO       = 8;
  localparam int EXT_NINTERRUPT = 4;
  localparam int NUM_SRC        = 16;
  localparam int SRC_ID_W       = 4;

  // Region bases, bits 31:16 are ignored
  localparam logic [15:0] SOC_CTRL_BASE = 16'h0000;
  localparam logic [15:0] GPIO_BASE     = 16'h1000;
  localparam logic [15:0] INTR_BASE     = 16'h2000;
  localparam logic [15:0] EXT_BASE      = 16'h3000;

  // Keeps the offset inside a region
  localparam logic [ADDR_W-1:0] OFFSET_MASK = 32'h0000_0fff;

  // SoC control
  localparam logic [4:0] EXIT_VALID = 5'h00;
  localparam logic [4:0] EXIT_VALUE = 5'h04;
  localparam logic [4:0] BOOT_MODE  = 5'h08;

  // GPIO
  localparam logic [4:0] GPIO_IN          = 5'h00;
  localparam logic [4:0] GPIO_OUT         = 5'h04;
  localparam logic [4:0] GPIO_EN          = 5'h08;
  localparam logic [4:0] GPIO_INTR_EN     = 5'h0c;
  localparam logic [4:0] GPIO_INTR_STATUS = 5'h10;

  // Interrupt controller
  localparam logic [4:0] INTR_PENDING = 5'h00;
  localparam logic [4:0] INTR_ENABLE  = 5'h04;
  localparam logic [4:0] INTR_CLAIM   = 5'h08;
  localparam logic [4:0] INTR_MSIP    = 5'h0c;

  typedef enum logic [2:0] {
    SEL_SOC_CTRL = 3'd0,
    SEL_GPIO     = 3'd1,
    SEL_INTR     = 3'd2,
    SEL_EXT      = 3'd3,
    SEL_NONE     = 3'd4
  } periph_sel_e;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    ISSUE   = 2'd1,
    RESPOND = 2'd2
  } bridge_state_e;

endpackage : periph_pkg
